//--- logic/id_remap_consts.svh
`ifndef ID_REMAP_CONSTS_SVH
`define ID_REMAP_CONSTS_SVH

`default_nettype none

// --------------------------------------------------
// id remap sizing
// --------------------------------------------------

// original and unique ids share one width
`define ID_REMAP_ID_WIDTH 4

`define ID_REMAP_NUM_ROWS 4 // distinct orig_ids in flight at once
`define ID_REMAP_NUM_COLS 4 // outstanding slots per orig_id

// row index in the upper bits of a unique id and column in the lower bits
`define ID_REMAP_ROW_W 2
`define ID_REMAP_COL_W 2

`default_nettype wire

`endif

//--- logic/id_remap_pkg.sv
`include "id_remap_consts.svh"

`default_nettype none

// shared types for the id remap unit
package id_remap_pkg;

    // original id as seen on the bus, also the unique id after remap
    typedef logic [`ID_REMAP_ID_WIDTH-1:0] orig_id_t;

    // table coordinates
    typedef logic [`ID_REMAP_ROW_W-1:0] row_idx_t;
    typedef logic [`ID_REMAP_COL_W-1:0] col_idx_t;

    // one valid bit per column of a row
    typedef logic [`ID_REMAP_NUM_COLS-1:0] slot_mask_t;

    // one bit per row (busy, full, hit)
    typedef logic [`ID_REMAP_NUM_ROWS-1:0] row_vec_t;

endpackage

`default_nettype wire

//--- logic/row_binder.sv
`include "id_remap_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module row_binder (
    input  logic                   clk,
    input  logic                   rst,         // sync, active high
    input  logic                   alloc_req,   // level, requester may hold it
    input  id_remap_pkg::orig_id_t orig_id,
    input  logic                   free_req,
    input  id_remap_pkg::row_idx_t free_row,    // upper half of free_uid
    input  id_remap_pkg::row_vec_t row_busy,    // mask non-zero per row
    input  id_remap_pkg::row_vec_t row_full,    // all columns valid per row
    output logic                   alloc_gnt,
    output id_remap_pkg::row_idx_t chosen_row,
    output id_remap_pkg::orig_id_t restored_id
);
    import id_remap_pkg::*;

    // --------------------------------------------------
    // bound id table
    // --------------------------------------------------
    // a row is bound exactly while its slot mask is non-zero,
    // so the stored id is only meaningful when row_busy is set
    orig_id_t bound_id [`ID_REMAP_NUM_ROWS];

    row_vec_t hit_vec;     // busy rows whose stored id equals orig_id
    logic     have_hit;
    row_idx_t hit_row;
    logic     have_empty;  // at least one unbound row
    row_idx_t empty_row;   // lowest unbound row
    logic     bind_new;    // grant goes to an unbound row

    // --------------------------------------------------
    // row search
    // --------------------------------------------------
    // at most one busy row holds a given id, new ids only bind on a miss
    always_comb begin : hit_search
        hit_vec = '0;
        hit_row = '0;
        for (int r = `ID_REMAP_NUM_ROWS - 1; r >= 0; r--) begin
            hit_vec[r] = row_busy[r] && (bound_id[r] == orig_id);
            if (hit_vec[r]) begin
                hit_row = row_idx_t'(r);
            end
        end
    end

    // scan from the top so the lowest free row wins
    always_comb begin : empty_search
        empty_row = '0;
        for (int r = `ID_REMAP_NUM_ROWS - 1; r >= 0; r--) begin
            if (!row_busy[r]) begin
                empty_row = row_idx_t'(r);
            end
        end
    end

    assign have_hit   = |hit_vec;
    assign have_empty = ~&row_busy;

    // --------------------------------------------------
    // grant decision
    // --------------------------------------------------
    // a hit never falls back to a fresh row, all requests of one id share a row
    assign chosen_row = have_hit ? hit_row : empty_row;
    assign alloc_gnt  = alloc_req && (have_hit ? !row_full[hit_row] : have_empty);
    assign bind_new   = alloc_gnt && !have_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                bound_id[r] <= '0;
            end
        end else if (bind_new) begin
            bound_id[empty_row] <= orig_id; // row becomes busy on the same edge
        end
    end

    // --------------------------------------------------
    // restore path
    // --------------------------------------------------
    // every slot of a row restores to the row's id, the column is not needed
    assign restored_id = free_req ? bound_id[free_row] : '0;

endmodule

`default_nettype wire

//--- logic/slot_tracker.sv
`include "id_remap_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module slot_tracker (
    input  logic                   clk,
    input  logic                   rst,        // sync, active high
    input  logic                   alloc_gnt,
    input  id_remap_pkg::row_idx_t chosen_row, // hit row or lowest empty row
    input  logic                   free_req,
    input  id_remap_pkg::row_idx_t free_row,
    input  id_remap_pkg::col_idx_t free_col,
    output id_remap_pkg::col_idx_t chosen_col, // lowest clear bit of chosen row
    output id_remap_pkg::row_vec_t row_busy,
    output id_remap_pkg::row_vec_t row_full,
    output logic                   id_full,
    output logic                   free_ack    // one cycle after free_req
);
    import id_remap_pkg::*;

    // --------------------------------------------------
    // slot valid masks
    // --------------------------------------------------
    slot_mask_t slot_mask [`ID_REMAP_NUM_ROWS]; // one bit per outstanding unique id
    slot_mask_t mask_next [`ID_REMAP_NUM_ROWS];
    slot_mask_t sel_mask;                       // mask of the row being allocated into

    assign sel_mask = slot_mask[chosen_row];

    // first free column, top down so column 0 has priority
    always_comb begin : col_pick
        chosen_col = '0; // row full, no grant follows
        for (int c = `ID_REMAP_NUM_COLS - 1; c >= 0; c--) begin
            if (!sel_mask[c]) begin
                chosen_col = col_idx_t'(c);
            end
        end
    end

    // --------------------------------------------------
    // row status
    // --------------------------------------------------
    always_comb begin : row_status
        for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
            row_busy[r] = |slot_mask[r]; // bound while anything is outstanding
            row_full[r] = &slot_mask[r];
        end
    end

    assign id_full = &row_full; // all 16 slots in flight

    // --------------------------------------------------
    // set and clear in one update
    // --------------------------------------------------
    // a grant only targets a clear bit and a free only a set bit,
    // so the two never hit the same slot
    always_comb begin : mask_update
        for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
            mask_next[r] = slot_mask[r];
        end
        if (free_req) begin
            mask_next[free_row][free_col] = 1'b0;
        end
        if (alloc_gnt) begin
            mask_next[chosen_row][chosen_col] = 1'b1; // keeps a row bound if its last slot frees now
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                slot_mask[r] <= '0;
            end
            free_ack <= 1'b0;
        end else begin
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                slot_mask[r] <= mask_next[r];
            end
            free_ack <= free_req; // pulses once per free cycle
        end
    end

endmodule

`default_nettype wire

//--- logic/id_remap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_unit (
    input  logic                   clk,
    input  logic                   rst,         // sync, active high

    // allocate side
    input  logic                   alloc_req,
    input  id_remap_pkg::orig_id_t orig_id,
    output logic                   alloc_gnt,   // same cycle as alloc_req
    output id_remap_pkg::orig_id_t unique_id,   // {row, col}
    output logic                   id_full,

    // free side
    input  logic                   free_req,
    input  id_remap_pkg::orig_id_t free_uid,
    output id_remap_pkg::orig_id_t restored_id, // zero while free_req is low
    output logic                   free_ack
);
    import id_remap_pkg::*;

    row_idx_t chosen_row;
    col_idx_t chosen_col;
    row_idx_t free_row;
    col_idx_t free_col;
    row_vec_t row_busy;
    row_vec_t row_full;

    // --------------------------------------------------
    // unique id packing
    // --------------------------------------------------
    assign {free_row, free_col} = free_uid;  // row half upper, column half lower
    assign unique_id = {chosen_row, chosen_col};

    row_binder row_binder_i (
        .clk        (clk),
        .rst        (rst),
        .alloc_req  (alloc_req),
        .orig_id    (orig_id),
        .free_req   (free_req),
        .free_row   (free_row),
        .row_busy   (row_busy),
        .row_full   (row_full),
        .alloc_gnt  (alloc_gnt),
        .chosen_row (chosen_row),
        .restored_id(restored_id)
    );

    slot_tracker slot_tracker_i (
        .clk       (clk),
        .rst       (rst),
        .alloc_gnt (alloc_gnt),
        .chosen_row(chosen_row),
        .free_req  (free_req),
        .free_row  (free_row),
        .free_col  (free_col),
        .chosen_col(chosen_col),
        .row_busy  (row_busy),
        .row_full  (row_full),
        .id_full   (id_full),
        .free_ack  (free_ack)
    );

endmodule

`default_nettype wire

//--- bench/id_remap_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_asserts (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_gnt,
    input  id_remap_pkg::row_idx_t chosen_row,
    input  logic                   free_req,
    input  id_remap_pkg::row_vec_t row_busy,
    input  id_remap_pkg::row_vec_t row_full,
    input  logic                   id_full,
    input  logic                   free_ack
);
    import id_remap_pkg::*;

    // --------------------------------------------------
    // slot tracker properties
    // --------------------------------------------------
    // ack is free_req delayed by exactly one edge
    free_ack_follows: assert property (@(posedge clk) disable iff (rst)
        free_ack == $past(free_req))
        else $error("free_ack does not follow free_req by one cycle");

    // a grant always lands in a row with a clear column
    grant_not_full: assert property (@(posedge clk) disable iff (rst)
        alloc_gnt |-> !row_full[chosen_row])
        else $error("grant targets a full row");

    // every row full leaves no free hit column and no unbound row to take
    full_no_bind: assert property (@(posedge clk) disable iff (rst)
        id_full |-> !alloc_gnt)
        else $error("grant while id_full is high");

endmodule

`default_nettype wire

//--- bench/id_remap_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_tb;
    import id_remap_pkg::*;

    typedef struct packed {
        logic [2:0] beh;       // behavior number of the test list
        logic       alloc_req;
        orig_id_t   orig_id;
        logic       free_req;
        orig_id_t   free_uid;
        logic       exp_gnt;
        orig_id_t   exp_uid;   // only checked on a grant
        orig_id_t   exp_rest;  // zero when nothing is freed
        logic       exp_full;  // reflects masks before the edge
    } step_t;

    localparam int num_steps      = 34;
    localparam int reset_cycles   = 5;
    localparam int timeout_cycles = reset_cycles + 2 * num_steps + 20;

    // --------------------------------------------------
    // stimulus and expected values
    // --------------------------------------------------
    // beh, areq, orig, freq, fuid, gnt, uid, restored, full
    localparam step_t steps [num_steps] = '{
        '{3'd1, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h0, 4'h0, 1'b0}, // id 5 binds row 0
        '{3'd1, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h1, 4'h0, 1'b0},
        '{3'd1, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h2, 4'h0, 1'b0},
        '{3'd1, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h3, 4'h0, 1'b0},
        '{3'd1, 1'b1, 4'h5, 1'b0, 4'h0, 1'b0, 4'h0, 4'h0, 1'b0}, // row 0 full, refused
        '{3'd2, 1'b1, 4'h9, 1'b0, 4'h0, 1'b1, 4'h4, 4'h0, 1'b0}, // id 9 takes row 1
        '{3'd2, 1'b1, 4'h9, 1'b0, 4'h0, 1'b1, 4'h5, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'h9, 1'b0, 4'h0, 1'b1, 4'h6, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'h9, 1'b0, 4'h0, 1'b1, 4'h7, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'ha, 1'b0, 4'h0, 1'b1, 4'h8, 4'h0, 1'b0}, // id a takes row 2
        '{3'd2, 1'b1, 4'ha, 1'b0, 4'h0, 1'b1, 4'h9, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'ha, 1'b0, 4'h0, 1'b1, 4'ha, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'ha, 1'b0, 4'h0, 1'b1, 4'hb, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'hc, 1'b0, 4'h0, 1'b1, 4'hc, 4'h0, 1'b0}, // id c takes row 3
        '{3'd2, 1'b1, 4'hc, 1'b0, 4'h0, 1'b1, 4'hd, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'hc, 1'b0, 4'h0, 1'b1, 4'he, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'hc, 1'b0, 4'h0, 1'b1, 4'hf, 4'h0, 1'b0},
        '{3'd2, 1'b1, 4'h3, 1'b0, 4'h0, 1'b0, 4'h0, 4'h0, 1'b1}, // all 16 out, new id refused
        '{3'd3, 1'b0, 4'h0, 1'b1, 4'h6, 1'b0, 4'h0, 4'h9, 1'b1}, // free row 1 col 2
        '{3'd4, 1'b1, 4'h9, 1'b0, 4'h0, 1'b1, 4'h6, 4'h0, 1'b0}, // col 2 reused
        '{3'd4, 1'b0, 4'h0, 1'b1, 4'h2, 1'b0, 4'h0, 4'h5, 1'b1},
        '{3'd4, 1'b0, 4'h0, 1'b1, 4'h1, 1'b0, 4'h0, 4'h5, 1'b0},
        '{3'd4, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h1, 4'h0, 1'b0}, // lowest hole first
        '{3'd4, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h2, 4'h0, 1'b0},
        '{3'd5, 1'b0, 4'h0, 1'b1, 4'h8, 1'b0, 4'h0, 4'ha, 1'b1}, // drain row 2
        '{3'd5, 1'b0, 4'h0, 1'b1, 4'h9, 1'b0, 4'h0, 4'ha, 1'b0},
        '{3'd5, 1'b0, 4'h0, 1'b1, 4'ha, 1'b0, 4'h0, 4'ha, 1'b0},
        '{3'd5, 1'b0, 4'h0, 1'b1, 4'hb, 1'b0, 4'h0, 4'ha, 1'b0},
        '{3'd5, 1'b1, 4'h3, 1'b0, 4'h0, 1'b1, 4'h8, 4'h0, 1'b0}, // id 3 rebinds row 2
        '{3'd6, 1'b1, 4'h3, 1'b1, 4'h8, 1'b1, 4'h9, 4'h3, 1'b0}, // hit while last slot frees
        '{3'd6, 1'b1, 4'h3, 1'b0, 4'h0, 1'b1, 4'h8, 4'h0, 1'b0}, // row 2 still bound to 3
        '{3'd6, 1'b1, 4'h3, 1'b1, 4'h0, 1'b1, 4'ha, 4'h5, 1'b0}, // alloc and free, two rows
        '{3'd6, 1'b1, 4'h5, 1'b0, 4'h0, 1'b1, 4'h0, 4'h0, 1'b0},
        '{3'd6, 1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 4'h0, 4'h0, 1'b0}  // idle
    };

    logic     clk = 1'b0;
    logic     rst;
    logic     alloc_req;
    orig_id_t orig_id;
    logic     alloc_gnt;
    orig_id_t unique_id;
    logic     id_full;
    logic     free_req;
    orig_id_t free_uid;
    orig_id_t restored_id;
    logic     free_ack;

    int err_cnt   = 0;
    int pass_cnt  = 0;
    int fail_cnt  = 0;
    int cycle_cnt = 0;

    id_remap_unit id_remap_unit_i (.*);

    bind slot_tracker id_remap_asserts slot_checks_i (
        .clk       (clk),
        .rst       (rst),
        .alloc_gnt (alloc_gnt),
        .chosen_row(chosen_row),
        .free_req  (free_req),
        .row_busy  (row_busy),
        .row_full  (row_full),
        .id_full   (id_full),
        .free_ack  (free_ack)
    );

    always #10 clk = ~clk; // 20 ns period

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [3:0] exp, input logic [3:0] got);
        assert (got === exp) else begin
            $display("Error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string label, input int beh, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s (behavior %0d): ok", label, beh);
        end else begin
            fail_cnt++;
            $display("test %s (behavior %0d): %0d mismatches", label, beh, errs);
        end
    endtask

    // hard stop in case the sequence never completes
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("timeout: sequence still running after %0d cycles", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // sequence
    // --------------------------------------------------
    initial begin
        int   errs_before;
        logic prev_free;
        rst       = 1'b1;
        alloc_req = 1'b0;
        orig_id   = '0;
        free_req  = 1'b0;
        free_uid  = '0;
        prev_free = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk); // idle outputs right after reset
        errs_before = err_cnt;
        check_value("alloc_gnt", 4'h0, {3'b0, alloc_gnt});
        check_value("free_ack", 4'h0, {3'b0, free_ack});
        check_value("id_full", 4'h0, {3'b0, id_full});
        report_test("reset", 0, err_cnt - errs_before);

        for (int i = 0; i < num_steps; i++) begin
            @(posedge clk);
            alloc_req <= steps[i].alloc_req;
            orig_id   <= steps[i].orig_id;
            free_req  <= steps[i].free_req;
            free_uid  <= steps[i].free_uid;
            @(negedge clk); // combinational outputs settled
            errs_before = err_cnt;
            check_value("alloc_gnt", {3'b0, steps[i].exp_gnt}, {3'b0, alloc_gnt});
            if (steps[i].exp_gnt) begin
                check_value("unique_id", steps[i].exp_uid, unique_id);
            end
            check_value("restored_id", steps[i].exp_rest, restored_id);
            check_value("id_full", {3'b0, steps[i].exp_full}, {3'b0, id_full});
            check_value("free_ack", {3'b0, prev_free}, {3'b0, free_ack});
            prev_free = steps[i].free_req;
            report_test($sformatf("%0d", i), int'(steps[i].beh), err_cnt - errs_before);
        end

        // one more cycle so the last entry's ack is seen
        @(posedge clk);
        alloc_req <= 1'b0;
        free_req  <= 1'b0;
        @(negedge clk);
        errs_before = err_cnt;
        check_value("free_ack", {3'b0, prev_free}, {3'b0, free_ack});
        report_test("drain", 3, err_cnt - errs_before);

        $display("tests passed %0d, failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- id_remap_unit.f
+incdir+logic
logic/id_remap_pkg.sv
logic/row_binder.sv
logic/slot_tracker.sv
logic/id_remap_unit.sv
bench/id_remap_asserts.sv
bench/id_remap_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the id remap testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module id_remap_tb \
    -f id_remap_unit.f \
    -o id_remap_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/id_remap_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log"; then
    echo "failure reported in $log"
    exit 1
fi

echo "simulation finished without reported failure"
exit 0
